//--- hw/nat_pkg.sv
// shared lane numbering, word bundle type and TTL/protocol word view
// for the NAT header rewrite pipeline
`default_nettype none

package nat_pkg;

    ////////////////////////////////////////////////////////////
    // lane numbering

    // one lane per 16-bit header word touched by the rewrite
    localparam int num_lanes = 5;

    localparam int lane_ttl_proto = 0;
    localparam int lane_src_hi    = 1;
    localparam int lane_src_lo    = 2;
    localparam int lane_dst_hi    = 3;
    localparam int lane_dst_lo    = 4;

    ////////////////////////////////////////////////////////////
    // types

    // ttl sits in the upper byte, as on the wire
    typedef struct packed {
        logic [7:0] ttl;
        logic [7:0] protocol;
    } ttl_proto_t;

    // same header word, seen as a checksum operand or as two fields
    typedef union packed {
        logic [15:0] word;
        ttl_proto_t  fields;
    } ttl_proto_u;

    // old or new words of every lane, index = lane number
    typedef logic [num_lanes-1:0][15:0] word_array_t;

endpackage

`default_nettype wire

//--- hw/nat_field_select.sv
// field selector: splits the header into lane words, builds the rewritten
// words and flags headers whose TTL runs out
`timescale 1ns/1ps
`default_nettype none

module nat_field_select (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 hdr_valid,
    input  wire logic [15:0]          hdr_checksum,
    input  wire nat_pkg::ttl_proto_u  hdr_ttl_proto,
    input  wire logic [31:0]          hdr_src_addr,
    input  wire logic [31:0]          hdr_dst_addr,
    input  wire logic                 src_rewrite_en,
    input  wire logic                 dst_rewrite_en,
    input  wire logic [31:0]          nat_src_addr,
    input  wire logic [31:0]          nat_dst_addr,
    output logic                      sel_valid,
    output logic [15:0]               sel_checksum,
    output nat_pkg::word_array_t      sel_old_words,
    output nat_pkg::word_array_t      sel_new_words,
    output logic                      sel_expired
);

    logic                 expiring;
    nat_pkg::ttl_proto_u  ttl_proto_dec;
    nat_pkg::word_array_t old_words;
    nat_pkg::word_array_t new_words;

    ////////////////////////////////////////////////////////////
    // word pairs

    // ttl of 0 or 1 cannot be forwarded
    assign expiring = (hdr_ttl_proto.fields.ttl <= 8'd1);

    always_comb begin
        ttl_proto_dec            = hdr_ttl_proto;
        ttl_proto_dec.fields.ttl = hdr_ttl_proto.fields.ttl - 8'd1;
    end

    always_comb begin
        old_words[nat_pkg::lane_ttl_proto] = hdr_ttl_proto.word;
        old_words[nat_pkg::lane_src_hi]    = hdr_src_addr[31:16];
        old_words[nat_pkg::lane_src_lo]    = hdr_src_addr[15:0];
        old_words[nat_pkg::lane_dst_hi]    = hdr_dst_addr[31:16];
        old_words[nat_pkg::lane_dst_lo]    = hdr_dst_addr[15:0];
    end

    // an expiring header keeps its old words, so every lane patch is a no-op
    always_comb begin
        new_words = old_words;
        if (!expiring) begin
            new_words[nat_pkg::lane_ttl_proto] = ttl_proto_dec.word;
            if (src_rewrite_en) begin
                new_words[nat_pkg::lane_src_hi] = nat_src_addr[31:16];
                new_words[nat_pkg::lane_src_lo] = nat_src_addr[15:0];
            end
            if (dst_rewrite_en) begin
                new_words[nat_pkg::lane_dst_hi] = nat_dst_addr[31:16];
                new_words[nat_pkg::lane_dst_lo] = nat_dst_addr[15:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_valid     <= 1'b0;
            sel_checksum  <= '0;
            sel_old_words <= '0;
            sel_new_words <= '0;
            sel_expired   <= 1'b0;
        end else begin
            sel_valid     <= hdr_valid;
            sel_checksum  <= hdr_checksum;
            sel_old_words <= old_words;
            sel_new_words <= new_words;
            // flag only travels with a real header
            sel_expired   <= hdr_valid & expiring;
        end
    end

endmodule

`default_nettype wire

//--- hw/csum_update_stage.sv
// one lane of the incremental checksum chain (RFC 1624, eqn. 3)
`timescale 1ns/1ps
`default_nettype none

module csum_update_stage #(
    parameter int lane = 0
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  in_valid,
    input  wire logic [15:0]           in_checksum,
    input  wire nat_pkg::word_array_t  in_old_words,
    input  wire nat_pkg::word_array_t  in_new_words,
    input  wire logic                  in_expired,
    output logic                       out_valid,
    output logic [15:0]                out_checksum,
    output nat_pkg::word_array_t       out_old_words,
    output nat_pkg::word_array_t       out_new_words,
    output logic                       out_expired
);

    logic [15:0] old_word;
    logic [15:0] new_word;
    logic [17:0] raw_sum;
    logic [16:0] fold_1;
    logic [15:0] fold_2;

    assign old_word = in_old_words[lane];
    assign new_word = in_new_words[lane];

    // ~hc + ~m + m', three 16-bit terms fit in 18 bits
    assign raw_sum = {2'b00, ~in_checksum} + {2'b00, ~old_word} + {2'b00, new_word};

    // end-around carry, second fold catches the carry of the first
    assign fold_1 = {1'b0, raw_sum[15:0]} + {15'd0, raw_sum[17:16]};
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid     <= 1'b0;
            out_checksum  <= '0;
            out_old_words <= '0;
            out_new_words <= '0;
            out_expired   <= 1'b0;
        end else begin
            out_valid     <= in_valid;
            out_checksum  <= ~fold_2;
            out_old_words <= in_old_words;
            out_new_words <= in_new_words;
            out_expired   <= in_expired;
        end
    end

endmodule

`default_nettype wire

//--- hw/nat_output_stage.sv
// output stage: rebuilds the header fields from the lane words and holds
// the last result between headers
`timescale 1ns/1ps
`default_nettype none

module nat_output_stage (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  in_valid,
    input  wire logic [15:0]           in_checksum,
    input  wire nat_pkg::word_array_t  in_new_words,
    input  wire logic                  in_expired,
    output logic                       out_valid,
    output logic [15:0]                out_checksum,
    output nat_pkg::ttl_proto_u        out_ttl_proto,
    output logic [31:0]                out_src_addr,
    output logic [31:0]                out_dst_addr,
    output logic                       out_expired
);

    nat_pkg::ttl_proto_u ttl_proto_word;
    logic [31:0]         src_addr;
    logic [31:0]         dst_addr;

    ////////////////////////////////////////////////////////////
    // field reassembly

    assign ttl_proto_word.word = in_new_words[nat_pkg::lane_ttl_proto];

    assign src_addr = {in_new_words[nat_pkg::lane_src_hi], in_new_words[nat_pkg::lane_src_lo]};
    assign dst_addr = {in_new_words[nat_pkg::lane_dst_hi], in_new_words[nat_pkg::lane_dst_lo]};

    ////////////////////////////////////////////////////////////
    // result registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;
            out_expired <= 1'b0;
        end else begin
            out_valid   <= in_valid;
            out_expired <= in_valid & in_expired;
        end
    end

    // data loads only with a header, so the fields stay put in idle cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_checksum  <= '0;
            out_ttl_proto <= '0;
            out_src_addr  <= '0;
            out_dst_addr  <= '0;
        end else if (in_valid) begin
            out_checksum                <= in_checksum;
            out_ttl_proto.fields.ttl      <= ttl_proto_word.fields.ttl;
            out_ttl_proto.fields.protocol <= ttl_proto_word.fields.protocol;
            out_src_addr                <= src_addr;
            out_dst_addr                <= dst_addr;
        end
    end

endmodule

`default_nettype wire

//--- hw/nat_rewrite_top.sv
// NAT header rewriter top level: field selector, checksum update chain
// and output stage, 7 cycles from hdr_valid to out_valid
`timescale 1ns/1ps
`default_nettype none

module nat_rewrite_top (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 hdr_valid,
    input  wire logic [15:0]          hdr_checksum,
    input  wire nat_pkg::ttl_proto_u  hdr_ttl_proto,
    input  wire logic [31:0]          hdr_src_addr,
    input  wire logic [31:0]          hdr_dst_addr,
    input  wire logic                 src_rewrite_en,
    input  wire logic                 dst_rewrite_en,
    input  wire logic [31:0]          nat_src_addr,
    input  wire logic [31:0]          nat_dst_addr,
    output logic                      out_valid,
    output logic [15:0]               out_checksum,
    output nat_pkg::ttl_proto_u       out_ttl_proto,
    output logic [31:0]               out_src_addr,
    output logic [31:0]               out_dst_addr,
    output logic                      out_expired
);

    ////////////////////////////////////////////////////////////
    // chain links

    // link 0 is the selector output, link k+1 the output of lane k
    logic                 chain_valid     [0:nat_pkg::num_lanes];
    logic [15:0]          chain_checksum  [0:nat_pkg::num_lanes];
    nat_pkg::word_array_t chain_old_words [0:nat_pkg::num_lanes];
    nat_pkg::word_array_t chain_new_words [0:nat_pkg::num_lanes];
    logic                 chain_expired   [0:nat_pkg::num_lanes];

    ////////////////////////////////////////////////////////////
    // field selection

    nat_field_select u_select (
        .clk            (clk),
        .arst_n         (arst_n),
        .hdr_valid      (hdr_valid),
        .hdr_checksum   (hdr_checksum),
        .hdr_ttl_proto  (hdr_ttl_proto),
        .hdr_src_addr   (hdr_src_addr),
        .hdr_dst_addr   (hdr_dst_addr),
        .src_rewrite_en (src_rewrite_en),
        .dst_rewrite_en (dst_rewrite_en),
        .nat_src_addr   (nat_src_addr),
        .nat_dst_addr   (nat_dst_addr),
        .sel_valid      (chain_valid[0]),
        .sel_checksum   (chain_checksum[0]),
        .sel_old_words  (chain_old_words[0]),
        .sel_new_words  (chain_new_words[0]),
        .sel_expired    (chain_expired[0])
    );

    ////////////////////////////////////////////////////////////
    // checksum update chain, one stage per lane

    for (genvar k = 0; k < nat_pkg::num_lanes; k++) begin : g_lane
        csum_update_stage #(
            .lane (k)
        ) u_stage (
            .clk           (clk),
            .arst_n        (arst_n),
            .in_valid      (chain_valid[k]),
            .in_checksum   (chain_checksum[k]),
            .in_old_words  (chain_old_words[k]),
            .in_new_words  (chain_new_words[k]),
            .in_expired    (chain_expired[k]),
            .out_valid     (chain_valid[k+1]),
            .out_checksum  (chain_checksum[k+1]),
            .out_old_words (chain_old_words[k+1]),
            .out_new_words (chain_new_words[k+1]),
            .out_expired   (chain_expired[k+1])
        );
    end

    ////////////////////////////////////////////////////////////
    // output stage

    nat_output_stage u_output (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (chain_valid[nat_pkg::num_lanes]),
        .in_checksum   (chain_checksum[nat_pkg::num_lanes]),
        .in_new_words  (chain_new_words[nat_pkg::num_lanes]),
        .in_expired    (chain_expired[nat_pkg::num_lanes]),
        .out_valid     (out_valid),
        .out_checksum  (out_checksum),
        .out_ttl_proto (out_ttl_proto),
        .out_src_addr  (out_src_addr),
        .out_dst_addr  (out_dst_addr),
        .out_expired   (out_expired)
    );

endmodule

`default_nettype wire

//--- tests/nat_rewrite_sva.sv
// bound checks on the NAT rewrite top level: reset, latency
// and pass-through of expired headers
`timescale 1ns/1ps
`default_nettype none

module nat_rewrite_sva (
    input wire logic                 clk,
    input wire logic                 arst_n,
    input wire logic                 hdr_valid,
    input wire logic [15:0]          hdr_checksum,
    input wire nat_pkg::ttl_proto_u  hdr_ttl_proto,
    input wire logic [31:0]          hdr_src_addr,
    input wire logic [31:0]          hdr_dst_addr,
    input wire logic                 out_valid,
    input wire logic [15:0]          out_checksum,
    input wire nat_pkg::ttl_proto_u  out_ttl_proto,
    input wire logic [31:0]          out_src_addr,
    input wire logic [31:0]          out_dst_addr,
    input wire logic                 out_expired
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // reset and latency

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid && !out_expired)
        else begin
            fail_count++;
            $error("out_valid or out_expired high while in reset");
        end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        hdr_valid |-> ##7 out_valid)
        else begin
            fail_count++;
            $error("no result 7 cycles after a header was presented");
        end

    // a result always traces back to a header 7 cycles before
    a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(hdr_valid, 7))
        else begin
            fail_count++;
            $error("out_valid rose without a header 7 cycles earlier");
        end

    ////////////////////////////////////////////////////////////
    // expired headers

    a_expired_flag: assert property (@(posedge clk) disable iff (!arst_n)
        hdr_valid && (hdr_ttl_proto.fields.ttl <= 8'd1) |-> ##7 out_expired)
        else begin
            fail_count++;
            $error("header with TTL 0 or 1 was not flagged as expired");
        end

    // the flag only ever comes from a header whose TTL ran out
    a_expired_cause: assert property (@(posedge clk) disable iff (!arst_n)
        out_expired |-> $past(hdr_valid && (hdr_ttl_proto.fields.ttl <= 8'd1), 7))
        else begin
            fail_count++;
            $error("out_expired high without an expiring header 7 cycles earlier");
        end

    a_expired_pass: assert property (@(posedge clk) disable iff (!arst_n)
        out_expired |-> (out_checksum == $past(hdr_checksum, 7))
                     && (out_ttl_proto == $past(hdr_ttl_proto, 7))
                     && (out_src_addr == $past(hdr_src_addr, 7))
                     && (out_dst_addr == $past(hdr_dst_addr, 7)))
        else begin
            fail_count++;
            $error("expired header was modified on its way through");
        end

endmodule

bind nat_rewrite_top nat_rewrite_sva u_sva (
    .clk           (clk),
    .arst_n        (arst_n),
    .hdr_valid     (hdr_valid),
    .hdr_checksum  (hdr_checksum),
    .hdr_ttl_proto (hdr_ttl_proto),
    .hdr_src_addr  (hdr_src_addr),
    .hdr_dst_addr  (hdr_dst_addr),
    .out_valid     (out_valid),
    .out_checksum  (out_checksum),
    .out_ttl_proto (out_ttl_proto),
    .out_src_addr  (out_src_addr),
    .out_dst_addr  (out_dst_addr),
    .out_expired   (out_expired)
);

`default_nettype wire

//--- tests/tb_nat_rewrite.sv
// testbench for the NAT header rewriter: random headers, from-scratch
// checksum reference, result queue and closing report
`timescale 1ns/1ps
`default_nettype none

module tb_nat_rewrite;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 3;

    // headers per phase and longest idle gap after a header
    localparam int n_plain   = 50;
    localparam int n_rewrite = 100;
    localparam int n_expired = 30;
    localparam int n_burst   = 120;
    localparam int gap_max   = 2;
    localparam int burst_gap = 3;

    localparam int total_cycles = reset_cycles + 20
        + (n_plain + n_rewrite + n_expired) * (1 + gap_max)
        + n_burst * (1 + burst_gap);

    logic                clk;
    logic                arst_n;
    logic                hdr_valid;
    logic [15:0]         hdr_checksum;
    nat_pkg::ttl_proto_u hdr_ttl_proto;
    logic [31:0]         hdr_src_addr;
    logic [31:0]         hdr_dst_addr;
    logic                src_rewrite_en;
    logic                dst_rewrite_en;
    logic [31:0]         nat_src_addr;
    logic [31:0]         nat_dst_addr;
    logic                out_valid;
    logic [15:0]         out_checksum;
    nat_pkg::ttl_proto_u out_ttl_proto;
    logic [31:0]         out_src_addr;
    logic [31:0]         out_dst_addr;
    logic                out_expired;

    // expected results, one entry per header in flight
    string       exp_name     [$];
    logic [15:0] exp_checksum [$];
    logic [15:0] exp_ttl      [$];
    logic [31:0] exp_src      [$];
    logic [31:0] exp_dst      [$];
    logic        exp_expired  [$];

    int errors = 0;
    int checks = 0;
    int sva_errors;

    nat_rewrite_top DUT (.*);

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model

    // full IPv4 header checksum, checksum field (word 5) taken as zero
    function automatic logic [15:0] header_checksum(input logic [159:0] hdr);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            if (i != 5)
                sum += hdr[159 - 16*i -: 16];
        end
        while (sum[31:16] != 0)
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        return ~sum[15:0];
    endfunction

    task automatic send_header(input string name, input logic [7:0] ttl,
                               input logic src_en, input logic dst_en);
        logic [7:0]   tos;
        logic [7:0]   proto;
        logic [7:0]   ttl_out;
        logic [15:0]  tot_len;
        logic [15:0]  ident;
        logic [15:0]  frag;
        logic [31:0]  src;
        logic [31:0]  dst;
        logic [31:0]  nsrc;
        logic [31:0]  ndst;
        logic [31:0]  src_out;
        logic [31:0]  dst_out;
        logic [159:0] hdr_in;
        logic [159:0] hdr_out;
        logic         expired;
        tos     = 8'($urandom);
        proto   = 8'($urandom);
        tot_len = 16'($urandom_range(20, 1500));
        ident   = 16'($urandom);
        frag    = 16'($urandom) & 16'h5fff;
        src     = $urandom;
        dst     = $urandom;
        nsrc    = $urandom;
        ndst    = $urandom;
        hdr_in  = {8'h45, tos, tot_len, ident, frag, ttl, proto, 16'h0000, src, dst};
        expired = (ttl < 8'd2);
        ttl_out = ttl;
        src_out = src;
        dst_out = dst;
        if (!expired) begin
            ttl_out = ttl - 8'd1;
            if (src_en)
                src_out = nsrc;
            if (dst_en)
                dst_out = ndst;
        end
        hdr_out = {8'h45, tos, tot_len, ident, frag, ttl_out, proto, 16'h0000, src_out, dst_out};

        @(posedge clk);
        hdr_valid      <= 1'b1;
        hdr_checksum   <= header_checksum(hdr_in);
        hdr_ttl_proto  <= {ttl, proto};
        hdr_src_addr   <= src;
        hdr_dst_addr   <= dst;
        src_rewrite_en <= src_en;
        dst_rewrite_en <= dst_en;
        nat_src_addr   <= nsrc;
        nat_dst_addr   <= ndst;

        exp_name.push_back(name);
        exp_checksum.push_back(header_checksum(hdr_out));
        exp_ttl.push_back({ttl_out, proto});
        exp_src.push_back(src_out);
        exp_dst.push_back(dst_out);
        exp_expired.push_back(expired);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        hdr_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus phases

    // mode 0 no rewrite, 1 random rewrite, 2 expired, 3 anything
    task automatic run_phase(input string name, input int count, input int mode,
                             input int max_gap, input int idle_odds);
        logic [7:0] ttl;
        logic       src_en;
        logic       dst_en;
        int         gap;
        for (int i = 0; i < count; i++) begin
            case (mode)
                0:       ttl = 8'($urandom_range(2, 255));
                1:       ttl = 8'($urandom_range(2, 255));
                2:       ttl = 8'($urandom_range(0, 1));
                default: ttl = 8'($urandom_range(0, 255));
            endcase
            src_en = (mode != 0) ? 1'($urandom) : 1'b0;
            dst_en = (mode != 0) ? 1'($urandom) : 1'b0;
            send_header(name, ttl, src_en, dst_en);
            gap = ($urandom_range(0, idle_odds) == 0) ? $urandom_range(1, max_gap) : 0;
            // burst opens with a long gapless run to fill the pipeline
            if (mode == 3 && i < 16)
                gap = 0;
            repeat (gap) idle_cycle();
        end
        idle_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // result checks

    always @(negedge clk) begin : check_results
        string       name;
        logic [15:0] e_csum;
        logic [15:0] e_ttl;
        logic [31:0] e_src;
        logic [31:0] e_dst;
        logic        e_exp;
        if (arst_n && out_valid) begin
            if (exp_name.size() == 0) begin
                errors++;
                $display("result appeared at %0t with no header outstanding", $time);
            end else begin
                name   = exp_name.pop_front();
                e_csum = exp_checksum.pop_front();
                e_ttl  = exp_ttl.pop_front();
                e_src  = exp_src.pop_front();
                e_dst  = exp_dst.pop_front();
                e_exp  = exp_expired.pop_front();
                checks++;
                assert (out_checksum == e_csum) else begin
                    errors++;
                    $display("Error: %s checksum expected %h actual %h", name, e_csum, out_checksum);
                end
                assert (out_ttl_proto == e_ttl) else begin
                    errors++;
                    $display("Error: %s ttl_proto expected %h actual %h", name, e_ttl,
                             out_ttl_proto);
                end
                assert (out_src_addr == e_src) else begin
                    errors++;
                    $display("Error: %s src_addr expected %h actual %h", name, e_src, out_src_addr);
                end
                assert (out_dst_addr == e_dst) else begin
                    errors++;
                    $display("Error: %s dst_addr expected %h actual %h", name, e_dst, out_dst_addr);
                end
                assert (out_expired == e_exp) else begin
                    errors++;
                    $display("Error: %s expired expected %b actual %b", name, e_exp, out_expired);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        void'($urandom(32'h43ff_684d));
        clk            = 1'b0;
        arst_n         = 1'b0;
        hdr_valid      = 1'b0;
        hdr_checksum   = '0;
        hdr_ttl_proto  = '0;
        hdr_src_addr   = '0;
        hdr_dst_addr   = '0;
        src_rewrite_en = 1'b0;
        dst_rewrite_en = 1'b0;
        nat_src_addr   = '0;
        nat_dst_addr   = '0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) idle_cycle();

        run_phase("no_rewrite", n_plain, 0, gap_max, 1);
        run_phase("random_rewrite", n_rewrite, 1, gap_max, 1);
        run_phase("expired_ttl", n_expired, 2, gap_max, 1);
        run_phase("back_to_back", n_burst, 3, burst_gap, 3);

        while (exp_name.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);

        sva_errors = DUT.u_sva.fail_count;
        $display("results checked %0d, compare errors %0d, assertion errors %0d",
                 checks, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(total_cycles * clk_period + 2000);
        $display("watchdog expired with %0d results still outstanding", exp_name.size());
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/nat_pkg.sv
hw/nat_field_select.sv
hw/csum_update_stage.sv
hw/nat_output_stage.sv
hw/nat_rewrite_top.sv
tests/nat_rewrite_sva.sv
tests/tb_nat_rewrite.sv
